// File: sym_adjust_settings.svh
`ifndef SYM_ADJUST_SETTINGS_SVH
`define SYM_ADJUST_SETTINGS_SVH

`define SA_WIDTH            16
`define SA_SUBFRAME_WIDTH   8
`define SA_ENER_BITWIDTH    10
`define SA_BRANCH_BITWIDTH  2
`define SA_SYM_BITWIDTH     2
`define SA_NUM_PATTERNS     4
`define SA_PATTERN_DEPTH    4

// three frames, less the part of the oldest one no group ever looks at.
`define SA_WINDOW           (3*`SA_WIDTH-`SA_SUBFRAME_WIDTH)

`define SA_FLAG_BITWIDTH    $clog2(2*`SA_NUM_PATTERNS+1)

`endif

// File: sym_adjust_pkg.sv
`include "sym_adjust_settings.svh"

package sym_adjust_pkg;

    // 0 is no event, 2k+1 is pattern k, 2k+2 is pattern k negated.
    typedef logic [`SA_FLAG_BITWIDTH-1:0] flag_t;

    typedef logic [`SA_ENER_BITWIDTH-1:0] ener_t;

    typedef logic signed [`SA_SYM_BITWIDTH-1:0] sym_t;

    typedef logic signed [`SA_BRANCH_BITWIDTH-1:0] branch_t;

    typedef enum logic [1:0] {
        SEQ_EMPTY,
        SEQ_PRIMING,
        SEQ_STREAMING
    } seq_state_t;

endpackage

// File: lowest_energy_flag_locator.sv
`include "sym_adjust_settings.svh"

module lowest_energy_flag_locator (
    input  sym_adjust_pkg::flag_t flags     [`SA_WIDTH-1:0],
    input  sym_adjust_pkg::ener_t flag_ener [`SA_WIDTH-1:0],
    output sym_adjust_pkg::flag_t best_flag [`SA_WIDTH-1:0]
);

    localparam int IDX_W = $clog2(`SA_WIDTH);

    logic                  found;
    logic [IDX_W-1:0]      best_idx;
    sym_adjust_pkg::ener_t best_ener;

    always_comb begin
        found     = 1'b0;
        best_idx  = '0;
        best_ener = '1;
        for (int i = 0; i < `SA_WIDTH; i += 1) begin
            // strict compare keeps the lower index on a tie.
            if (flags[i] != '0 && (!found || flag_ener[i] < best_ener)) begin
                found     = 1'b1;
                best_idx  = IDX_W'(i);
                best_ener = flag_ener[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SA_WIDTH; i += 1) begin
            best_flag[i] = (found && best_idx == IDX_W'(i)) ? flags[i] : '0;
        end
    end

endmodule

// File: flag_window_buffer.sv
`include "sym_adjust_settings.svh"

module flag_window_buffer #(
    parameter type payload_t = logic
)(
    input  logic     clk,
    input  logic     rst,
    input  logic     shift_in,
    input  logic     clear,
    input  payload_t frame_in [`SA_WIDTH-1:0],
    output payload_t window   [`SA_WINDOW-1:0]
);

    // newest frame sits at the low indices, older frames move up by one frame per strobe.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            for (int i = 0; i < `SA_WINDOW; i += 1) begin
                window[i] <= '0;
            end
        end else if (shift_in) begin
            for (int i = 0; i < `SA_WIDTH; i += 1) begin
                window[i] <= frame_in[i];
            end
            for (int i = `SA_WIDTH; i < `SA_WINDOW; i += 1) begin
                window[i] <= window[i-`SA_WIDTH];
            end
        end
    end

    // a clear must win over a shift, so both ends of the window read zero afterwards.
    a_clear_wins: assert property (
        @(posedge clk) disable iff (rst)
        clear |=> (window[0] == '0 && window[`SA_WINDOW-1] == '0)
    );

endmodule

// File: wide_subframe_symbol_adjust_locator.sv
`include "sym_adjust_settings.svh"

module wide_subframe_symbol_adjust_locator (
    input  sym_adjust_pkg::flag_t   flags            [`SA_WINDOW-1:0],
    input  sym_adjust_pkg::ener_t   flag_ener        [`SA_WINDOW-1:0],
    input  sym_adjust_pkg::branch_t trellis_patterns
                                    [`SA_NUM_PATTERNS-1:0][`SA_PATTERN_DEPTH-1:0],
    output sym_adjust_pkg::sym_t    symbol_adjust    [`SA_WIDTH-1:0]
);

    localparam int W         = `SA_WIDTH;
    localparam int S         = `SA_SUBFRAME_WIDTH;
    localparam int D         = `SA_PATTERN_DEPTH;
    localparam int NUM_CODES = 2 ** `SA_FLAG_BITWIDTH;
    localparam int ACC_W     = `SA_BRANCH_BITWIDTH + `SA_SYM_BITWIDTH + $clog2(D) + 1;
    localparam int SYM_MAX   = (1 << (`SA_SYM_BITWIDTH - 1)) - 1;
    localparam int SYM_MIN   = -(1 << (`SA_SYM_BITWIDTH - 1));

    sym_adjust_pkg::flag_t   best_blk  [1:0][W-1:0];
    sym_adjust_pkg::flag_t   best_red  [1:0][W-1:0];
    sym_adjust_pkg::flag_t   blk_frame [2*W-1:0];
    sym_adjust_pkg::flag_t   red_frame [2*W-1:0];
    sym_adjust_pkg::flag_t   selected  [2*W-1:0];
    logic signed [ACC_W-1:0] unfolded  [NUM_CODES-1:0][D-1:0];
    logic signed [ACC_W-1:0] acc       [2*W-1:0];

    // black groups are frame aligned, red groups are shifted by one subframe.
    for (genvar g = 0; g < 2; g += 1) begin : g_grp
        lowest_energy_flag_locator u_blk_loc (
            .flags     (flags[(g+1)*W-1:g*W]),
            .flag_ener (flag_ener[(g+1)*W-1:g*W]),
            .best_flag (best_blk[g])
        );

        lowest_energy_flag_locator u_red_loc (
            .flags     (flags[(g+2)*W-S-1:(g+1)*W-S]),
            .flag_ener (flag_ener[(g+2)*W-S-1:(g+1)*W-S]),
            .best_flag (best_red[g])
        );
    end

    // index c of both frames maps to window position c + W - S.
    always_comb begin
        for (int c = 0; c < 2*W; c += 1) begin
            if (c < W) begin
                red_frame[c] = best_red[0][c];
            end else begin
                red_frame[c] = best_red[1][c-W];
            end

            if (c < S) begin
                blk_frame[c] = best_blk[0][c+W-S];
            end else if (c < W + S) begin
                blk_frame[c] = best_blk[1][c-S];
            end else begin
                blk_frame[c] = '0;
            end
        end
    end

    // codes past 2*N stay zero so any flag value is a safe index.
    always_comb begin
        for (int f = 0; f < NUM_CODES; f += 1) begin
            for (int j = 0; j < D; j += 1) begin
                unfolded[f][j] = '0;
            end
        end
        for (int k = 0; k < `SA_NUM_PATTERNS; k += 1) begin
            for (int j = 0; j < D; j += 1) begin
                unfolded[2*k+1][j] = trellis_patterns[k][j];
                unfolded[2*k+2][j] = -trellis_patterns[k][j];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < 2*W; c += 1) begin
            selected[c] = '0;
            acc[c]      = '0;
        end
        // only events starting at S-D or later can reach the output span.
        for (int c = S - D; c < W + S; c += 1) begin
            selected[c] = (red_frame[c] == blk_frame[c]) ? blk_frame[c] : '0;
            for (int j = 0; j < D; j += 1) begin
                acc[c+j] = acc[c+j] + unfolded[selected[c]][j];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < W; i += 1) begin
            if (acc[i+S] > SYM_MAX) begin
                symbol_adjust[i] = sym_adjust_pkg::sym_t'(SYM_MAX);
            end else if (acc[i+S] < SYM_MIN) begin
                symbol_adjust[i] = sym_adjust_pkg::sym_t'(SYM_MIN);
            end else begin
                symbol_adjust[i] = acc[i+S][`SA_SYM_BITWIDTH-1:0];
            end
        end
    end

endmodule

// File: frame_sequencer.sv
module frame_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic                       flush,
    input  logic [1:0]                 frames_loaded,
    output logic                       advance,
    output logic                       clear,
    output sym_adjust_pkg::seq_state_t state
);

    sym_adjust_pkg::seq_state_t state_next;
    logic                       window_full;

    assign window_full = (state == sym_adjust_pkg::SEQ_STREAMING) ||
                         (state == sym_adjust_pkg::SEQ_PRIMING && frames_loaded == 2'd2);

    assign advance = in_valid && !flush && window_full;  // flush wins over a strobe.
    assign clear   = flush;

    always_comb begin
        state_next = state;
        if (flush) begin
            state_next = sym_adjust_pkg::SEQ_EMPTY;
        end else if (in_valid) begin
            case (state)
                sym_adjust_pkg::SEQ_EMPTY:   state_next = sym_adjust_pkg::SEQ_PRIMING;
                sym_adjust_pkg::SEQ_PRIMING: begin
                    if (frames_loaded == 2'd2) begin
                        state_next = sym_adjust_pkg::SEQ_STREAMING;
                    end
                end
                default:                     state_next = state;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sym_adjust_pkg::SEQ_EMPTY;
        end else begin
            state <= state_next;
        end
    end

    a_no_advance_empty: assert property (
        @(posedge clk) disable iff (rst)
        (state == sym_adjust_pkg::SEQ_EMPTY) |-> !advance
    );

endmodule

// File: frame_counter.sv
module frame_counter (
    input  logic                       clk,
    input  logic                       rst,
    input  sym_adjust_pkg::seq_state_t state,
    input  logic                       in_valid,
    input  logic                       advance,
    input  logic                       clear,
    output logic [1:0]                 frames_loaded,
    output logic [7:0]                 frame_seq
);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            frames_loaded <= 2'd0;
            frame_seq     <= 8'd0;
        end else begin
            if (in_valid && state != sym_adjust_pkg::SEQ_STREAMING &&
                frames_loaded != 2'd2) begin
                frames_loaded <= frames_loaded + 2'd1;  // saturates once two frames are held.
            end
            if (advance) begin
                frame_seq <= frame_seq + 8'd1;  // wraps at 256.
            end
        end
    end

endmodule

// File: symbol_corrector.sv
`include "sym_adjust_settings.svh"

module symbol_corrector (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,
    input  logic [7:0]           frame_seq,
    input  sym_adjust_pkg::sym_t prev_symbols  [`SA_WIDTH-1:0],
    input  sym_adjust_pkg::sym_t symbol_adjust [`SA_WIDTH-1:0],
    output logic                 out_valid,
    output sym_adjust_pkg::sym_t out_symbols   [`SA_WIDTH-1:0],
    output logic [7:0]           out_frame_seq
);

    localparam int SUM_W   = `SA_SYM_BITWIDTH + 1;
    localparam int SYM_MAX = (1 << (`SA_SYM_BITWIDTH - 1)) - 1;
    localparam int SYM_MIN = -(1 << (`SA_SYM_BITWIDTH - 1));

    logic signed [SUM_W-1:0] sum [`SA_WIDTH-1:0];

    always_comb begin
        for (int i = 0; i < `SA_WIDTH; i += 1) begin
            sum[i] = SUM_W'(prev_symbols[i]) + SUM_W'(symbol_adjust[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= advance;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_frame_seq <= frame_seq;
            for (int i = 0; i < `SA_WIDTH; i += 1) begin
                if (sum[i] > SYM_MAX) begin
                    out_symbols[i] <= sym_adjust_pkg::sym_t'(SYM_MAX);
                end else if (sum[i] < SYM_MIN) begin
                    out_symbols[i] <= sym_adjust_pkg::sym_t'(SYM_MIN);
                end else begin
                    out_symbols[i] <= sum[i][`SA_SYM_BITWIDTH-1:0];
                end
            end
        end
    end

    // back to back outputs only come from back to back strobes.
    a_valid_pairs: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && $past(out_valid)) |-> ($past(advance) && $past(advance, 2))
    );

endmodule

// File: sym_adjust_top.sv
`include "sym_adjust_settings.svh"

module sym_adjust_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  sym_adjust_pkg::flag_t   in_flags   [`SA_WIDTH-1:0],
    input  sym_adjust_pkg::ener_t   in_ener    [`SA_WIDTH-1:0],
    input  sym_adjust_pkg::sym_t    in_symbols [`SA_WIDTH-1:0],
    input  logic                    flush,
    input  sym_adjust_pkg::branch_t trellis_patterns
                                    [`SA_NUM_PATTERNS-1:0][`SA_PATTERN_DEPTH-1:0],
    output logic                    out_valid,
    output sym_adjust_pkg::sym_t    out_symbols [`SA_WIDTH-1:0],
    output logic [7:0]              out_frame_seq
);

    sym_adjust_pkg::flag_t      flag_window   [`SA_WINDOW-1:0];
    sym_adjust_pkg::ener_t      ener_window   [`SA_WINDOW-1:0];
    sym_adjust_pkg::sym_t       sym_window    [`SA_WINDOW-1:0];
    sym_adjust_pkg::sym_t       symbol_adjust [`SA_WIDTH-1:0];
    sym_adjust_pkg::seq_state_t state;
    logic                       advance;
    logic                       clear;
    logic [1:0]                 frames_loaded;
    logic [7:0]                 frame_seq;

    flag_window_buffer #(.payload_t(sym_adjust_pkg::flag_t)) u_flag_buf (
        .clk(clk), .rst(rst), .shift_in(in_valid), .clear(clear),
        .frame_in(in_flags), .window(flag_window)
    );

    flag_window_buffer #(.payload_t(sym_adjust_pkg::ener_t)) u_ener_buf (
        .clk(clk), .rst(rst), .shift_in(in_valid), .clear(clear),
        .frame_in(in_ener), .window(ener_window)
    );

    flag_window_buffer #(.payload_t(sym_adjust_pkg::sym_t)) u_sym_buf (
        .clk(clk), .rst(rst), .shift_in(in_valid), .clear(clear),
        .frame_in(in_symbols), .window(sym_window)
    );

    wide_subframe_symbol_adjust_locator u_locator (
        .flags(flag_window), .flag_ener(ener_window),
        .trellis_patterns(trellis_patterns), .symbol_adjust(symbol_adjust)
    );

    frame_sequencer u_sequencer (
        .clk(clk), .rst(rst), .in_valid(in_valid), .flush(flush),
        .frames_loaded(frames_loaded), .advance(advance), .clear(clear), .state(state)
    );

    frame_counter u_counter (
        .clk(clk), .rst(rst), .state(state), .in_valid(in_valid), .advance(advance),
        .clear(clear), .frames_loaded(frames_loaded), .frame_seq(frame_seq)
    );

    // the frame one older than the newest is the one being corrected.
    symbol_corrector u_corrector (
        .clk(clk), .rst(rst), .advance(advance), .frame_seq(frame_seq),
        .prev_symbols(sym_window[2*`SA_WIDTH-1:`SA_WIDTH]),
        .symbol_adjust(symbol_adjust), .out_valid(out_valid),
        .out_symbols(out_symbols), .out_frame_seq(out_frame_seq)
    );

endmodule

// File: tb_sym_adjust.sv
`include "sym_adjust_settings.svh"

module tb_sym_adjust;

    localparam int W       = `SA_WIDTH;
    localparam int MAX_REC = 64;

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    logic                    flush;
    sym_adjust_pkg::flag_t   in_flags   [W-1:0];
    sym_adjust_pkg::ener_t   in_ener    [W-1:0];
    sym_adjust_pkg::sym_t    in_symbols [W-1:0];
    sym_adjust_pkg::branch_t trellis_patterns [`SA_NUM_PATTERNS-1:0][`SA_PATTERN_DEPTH-1:0];
    logic                    out_valid;
    sym_adjust_pkg::sym_t    out_symbols [W-1:0];
    logic [7:0]              out_frame_seq;

    logic [127:0] rec_name     [MAX_REC];
    logic [39:0]  rec_op       [MAX_REC];
    logic [63:0]  rec_flags    [MAX_REC];
    logic [191:0] rec_ener     [MAX_REC];
    logic [31:0]  rec_syms     [MAX_REC];
    logic         rec_expect   [MAX_REC];
    logic [31:0]  rec_exp_syms [MAX_REC];
    logic [7:0]   rec_exp_seq  [MAX_REC];
    int           num_rec;
    int           pass_count;
    int           fail_count;
    int           seed;
    logic         loaded;

    sym_adjust_top u_dut (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_flags(in_flags), .in_ener(in_ener),
        .in_symbols(in_symbols), .flush(flush), .trellis_patterns(trellis_patterns),
        .out_valid(out_valid), .out_symbols(out_symbols), .out_frame_seq(out_frame_seq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic read_stimulus();
        int           fd;
        int           n;
        int           vals [16];
        string        line;
        logic [127:0] word;
        fd = $fopen("sym_adjust_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open sym_adjust_stimulus.txt");
            fail_count += 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() < 2 || line.getc(0) == "#") continue;
                n = $sscanf(line, "%s", word);
                if (word == "patterns") begin
                    n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", word,
                                vals[0], vals[1], vals[2], vals[3], vals[4], vals[5],
                                vals[6], vals[7], vals[8], vals[9], vals[10], vals[11],
                                vals[12], vals[13], vals[14], vals[15]);
                    for (int k = 0; k < `SA_NUM_PATTERNS; k += 1) begin
                        for (int j = 0; j < `SA_PATTERN_DEPTH; j += 1) begin
                            trellis_patterns[k][j] = sym_adjust_pkg::branch_t'(vals[4*k+j]);
                        end
                    end
                end else begin
                    n = $sscanf(line, "%s %s %h %h %h %d %h %h", rec_name[num_rec],
                                rec_op[num_rec], rec_flags[num_rec], rec_ener[num_rec],
                                rec_syms[num_rec], rec_expect[num_rec],
                                rec_exp_syms[num_rec], rec_exp_seq[num_rec]);
                    if (n != 8) begin
                        $display("a record line in the stimulus file could not be read");
                        fail_count += 1;
                    end
                    num_rec += 1;
                end
            end
            $fclose(fd);
        end
    endtask

    // flags take 4 bits, energies 12 bits and symbols 2 bits per position in a record.
    task automatic apply_record(input int r);
        for (int i = 0; i < W; i += 1) begin
            in_flags[i]   = rec_flags[r][4*i +: 4];
            in_ener[i]    = rec_ener[r][12*i +: 10];
            in_symbols[i] = rec_syms[r][2*i +: 2];
        end
        if (rec_op[r] == "flush") begin
            flush = 1'b1;
        end else begin
            in_valid = 1'b1;
        end
    endtask

    task automatic check_record(input int r);
        logic [31:0] got;
        logic        ok;
        for (int i = 0; i < W; i += 1) begin
            got[2*i +: 2] = out_symbols[i];
        end
        ok = 1'b1;
        assert (out_valid == rec_expect[r]) else begin
            $display("ERROR %0s out_valid expected %0d actual %0d",
                     rec_name[r], rec_expect[r], out_valid);
            ok = 1'b0;
        end
        if (rec_expect[r] && out_valid) begin
            assert (got == rec_exp_syms[r]) else begin
                $display("ERROR %0s out_symbols expected %h actual %h",
                         rec_name[r], rec_exp_syms[r], got);
                ok = 1'b0;
            end
            assert (out_frame_seq == rec_exp_seq[r]) else begin
                $display("ERROR %0s out_frame_seq expected %0d actual %0d",
                         rec_name[r], rec_exp_seq[r], out_frame_seq);
                ok = 1'b0;
            end
        end
        if (ok) begin
            pass_count += 1;
            $display("PASS %0s", rec_name[r]);
        end else begin
            fail_count += 1;
            $display("FAIL %0s", rec_name[r]);
        end
    endtask

    // each record needs at most four cycles, ten more cover reset.
    initial begin
        wait (loaded);
        #((num_rec + 10) * 8 * 4);
        $display("timeout, the tests did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int gap;
        seed       = 32'h4d75e1c8;
        rst        = 1'b1;
        in_valid   = 1'b0;
        flush      = 1'b0;
        num_rec    = 0;
        pass_count = 0;
        fail_count = 0;
        loaded     = 1'b0;
        for (int i = 0; i < W; i += 1) begin
            in_flags[i]   = '0;
            in_ener[i]    = '0;
            in_symbols[i] = '0;
        end
        for (int k = 0; k < `SA_NUM_PATTERNS; k += 1) begin
            for (int j = 0; j < `SA_PATTERN_DEPTH; j += 1) begin
                trellis_patterns[k][j] = '0;
            end
        end
        read_stimulus();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int r = 0; r < num_rec; r += 1) begin
            @(posedge clk);
            #1;
            apply_record(r);
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            flush    = 1'b0;
            check_record(r);
            gap = ($random(seed) & 32'h7fffffff) % 3;
            repeat (gap) @(posedge clk);
        end
        $display("tests %0d, passed %0d, failed %0d", num_rec, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sym_adjust_stimulus.txt
# patterns line: k0..k3, entries j0..j3 each. records: name op flags ener syms expect exp_syms exp_seq
# flags 4 bits, ener 12 bits (low 10 used), syms 2 bits per position, position 0 in the low bits
patterns 1 0 -1 1 1 1 1 1 -1 -1 0 1 -2 1 0 -1
prime_a frame 0 0 9c6a35f0 0 0 0
prime_b frame 0 0 0123abcd 0 0 0
first_out frame 0 0 fedc5432 1 9c6a35f0 00
second_out frame 0 0 0 1 0123abcd 01
flush_all flush 0 0 0 0 0 0
reprime_a frame 0 0 13579bdf 0 0 0
reprime_b frame 30000001000 2000000000000000000005000000000 0 0 0 0
restart_seq frame 5310000 9007007000000000000 0 1 13579bdf 00
disagree frame 100 0 0 1 05500000 01
energy_tie frame 400000 0 0 1 00007100 02
odd_flag frame 80 0 264 1 00000710 03
even_flag frame 0 0 0 1 0003fc00 04
saturate frame 0 0 0 1 00000364 05

// File: src.f
+incdir+.
sym_adjust_pkg.sv
lowest_energy_flag_locator.sv
flag_window_buffer.sv
wide_subframe_symbol_adjust_locator.sv
frame_sequencer.sv
frame_counter.sv
symbol_corrector.sv
sym_adjust_top.sv
tb_sym_adjust.sv

// File: run_sim.sh
#!/bin/sh
set -e
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_sym_adjust \
    -o sim_sym_adjust
./obj_dir/sim_sym_adjust > sim.log 2>&1
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
